// File: verilog/wbk_cfg_pkg.sv
package wbk_cfg_pkg;

    typedef logic [5:0]  wb_addr_t;  // word address on the register port
    typedef logic [31:0] wb_data_t;

    // register map, one 32-bit word per address
    localparam wb_addr_t REG_OFFSET0   = 6'd0;
    localparam wb_addr_t REG_OFFSET1   = 6'd1;
    localparam wb_addr_t REG_OFFSET2   = 6'd2;
    localparam wb_addr_t REG_STORE     = 6'd3;  // bit 31 picks the input base
    localparam wb_addr_t REG_LENGTH    = 6'd4;
    localparam wb_addr_t REG_CONTROL   = 6'd5;
    localparam wb_addr_t REG_STATUS    = 6'd6;  // read only
    localparam wb_addr_t REG_IN_BASE   = 6'd7;
    localparam wb_addr_t REG_OUT_BASE  = 6'd8;
    localparam wb_addr_t REG_CHAN_BASE = 6'd16; // channel c sits at this plus c

    // bits of REG_CONTROL, the channel number lives in bits 2:0
    localparam int CTRL_FENCE_BIT = 4;
    localparam int CTRL_SYNTH_BIT = 5;
    localparam int CTRL_START_BIT = 8;

    // command as the engine sees it at start
    typedef struct packed {
        logic [2:0][31:0] offsets;       // added to the base one per cycle
        logic             store_in_base;
        logic [30:0]      store_offset;
        logic [31:0]      length;        // lines to write
        logic [2:0]       channel;
        logic             fence;         // wait for every write response
        logic             synthetic;
        logic [31:0]      in_base;
        logic [31:0]      out_base;
    } wb_cmd_t;

    // per-channel read window, one register word
    typedef struct packed {
        logic [15:0] first_index;
        logic [15:0] count;
    } chan_cfg_t;

endpackage

// File: verilog/host_mem_pkg.sv
package host_mem_pkg;

    localparam int LINE_WIDTH = 128;
    localparam int LINE_WORDS = 4;   // 32-bit words per line

    typedef logic [31:0]           line_addr_t;  // counts whole lines
    typedef logic [LINE_WIDTH-1:0] line_t;

    // one posted write, valid for a single cycle
    typedef struct packed {
        logic       valid;
        line_addr_t addr;
        line_t      data;
    } host_wr_req_t;

    // write completion, one pulse per accepted request and in order
    typedef struct packed {
        logic valid;
    } host_wr_rsp_t;

    // loads a line into one channel buffer
    typedef struct packed {
        logic        valid;
        logic [2:0]  channel;
        logic [15:0] index;
        line_t       data;
    } line_fill_t;

endpackage

// File: verilog/wbk_regfile.sv
module wbk_regfile #(
    parameter int NUM_CHANNELS = 2
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  wbk_cfg_pkg::wb_addr_t wb_adr,
    input  wbk_cfg_pkg::wb_data_t wb_dat_w,
    output wbk_cfg_pkg::wb_data_t wb_dat_r,
    output logic                  wb_ack,

    input  logic                  op_done,
    output logic                  start,
    output wbk_cfg_pkg::wb_cmd_t  cmd,
    output wbk_cfg_pkg::chan_cfg_t chan_cfg [NUM_CHANNELS]
);

    logic                  access;     // new cycle seen, ack goes out next
    logic                  start_arm;  // start accepted, pulse follows the ack
    logic                  busy;
    logic                  done;
    wbk_cfg_pkg::wb_data_t read_word;

    assign access = wb_cyc && wb_stb && !wb_ack;

    always_comb
    begin
        read_word = '0;  // unmapped words read as zero
        case (wb_adr)
            wbk_cfg_pkg::REG_OFFSET0:  read_word = cmd.offsets[0];
            wbk_cfg_pkg::REG_OFFSET1:  read_word = cmd.offsets[1];
            wbk_cfg_pkg::REG_OFFSET2:  read_word = cmd.offsets[2];
            wbk_cfg_pkg::REG_STORE:    read_word = {cmd.store_in_base, cmd.store_offset};
            wbk_cfg_pkg::REG_LENGTH:   read_word = cmd.length;
            wbk_cfg_pkg::REG_CONTROL:
            begin
                read_word[2:0] = cmd.channel;
                read_word[wbk_cfg_pkg::CTRL_FENCE_BIT] = cmd.fence;
                read_word[wbk_cfg_pkg::CTRL_SYNTH_BIT] = cmd.synthetic;
            end
            wbk_cfg_pkg::REG_STATUS:   read_word = {30'b0, done, busy};
            wbk_cfg_pkg::REG_IN_BASE:  read_word = cmd.in_base;
            wbk_cfg_pkg::REG_OUT_BASE: read_word = cmd.out_base;
            default:                   read_word = '0;
        endcase
        for (int c = 0; c < NUM_CHANNELS; c++)
        begin
            if (wb_adr == wbk_cfg_pkg::wb_addr_t'(wbk_cfg_pkg::REG_CHAN_BASE + c))
                read_word = chan_cfg[c];
        end
    end

    always_ff @(posedge clk)
    begin
        if (access)
            wb_dat_r <= read_word;  // lands together with ack
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_ack    <= 1'b0;
            start_arm <= 1'b0;
            start     <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            cmd       <= '0;
            for (int c = 0; c < NUM_CHANNELS; c++)
                chan_cfg[c] <= '0;
        end
        else
        begin
            wb_ack    <= access;
            start     <= start_arm;
            start_arm <= 1'b0;

            if (op_done)
            begin
                busy <= 1'b0;
                done <= 1'b1;  // sticky until the next accepted start
            end

            if (access && wb_we)
            begin
                case (wb_adr)
                    wbk_cfg_pkg::REG_OFFSET0:  cmd.offsets[0] <= wb_dat_w;
                    wbk_cfg_pkg::REG_OFFSET1:  cmd.offsets[1] <= wb_dat_w;
                    wbk_cfg_pkg::REG_OFFSET2:  cmd.offsets[2] <= wb_dat_w;
                    wbk_cfg_pkg::REG_STORE:    {cmd.store_in_base, cmd.store_offset} <= wb_dat_w;
                    wbk_cfg_pkg::REG_LENGTH:   cmd.length <= wb_dat_w;
                    wbk_cfg_pkg::REG_CONTROL:
                    begin
                        cmd.channel   <= wb_dat_w[2:0];
                        cmd.fence     <= wb_dat_w[wbk_cfg_pkg::CTRL_FENCE_BIT];
                        cmd.synthetic <= wb_dat_w[wbk_cfg_pkg::CTRL_SYNTH_BIT];
                        if (wb_dat_w[wbk_cfg_pkg::CTRL_START_BIT] && !busy)
                        begin
                            start_arm <= 1'b1;
                            busy      <= 1'b1;  // a second start now gets ignored
                            done      <= 1'b0;
                        end
                    end
                    wbk_cfg_pkg::REG_IN_BASE:  cmd.in_base <= wb_dat_w;
                    wbk_cfg_pkg::REG_OUT_BASE: cmd.out_base <= wb_dat_w;
                    default:                   ;
                endcase
                for (int c = 0; c < NUM_CHANNELS; c++)
                begin
                    if (wb_adr == wbk_cfg_pkg::wb_addr_t'(wbk_cfg_pkg::REG_CHAN_BASE + c))
                        chan_cfg[c] <= wb_dat_w;
                end
            end
        end
    end

endmodule

// File: verilog/line_reader.sv
module line_reader #(
    parameter int CHANNEL_DEPTH = 64
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic [2:0]             chan_id,
    input  host_mem_pkg::line_fill_t fill,

    input  logic                   start,
    input  wbk_cfg_pkg::chan_cfg_t cfg,
    input  logic                   almost_full,
    output host_mem_pkg::line_t    rd_line,
    output logic                   rd_valid
);

    localparam int AW = (CHANNEL_DEPTH > 1) ? $clog2(CHANNEL_DEPTH) : 1;

    host_mem_pkg::line_t mem [CHANNEL_DEPTH];
    logic [AW-1:0]       rd_addr;
    logic [15:0]         remaining;  // lines still to read in this run
    logic                fill_hit;
    logic                do_read;

    assign fill_hit = fill.valid && (fill.channel == chan_id)
                   && (fill.index < 16'(CHANNEL_DEPTH));

    // one read per cycle while the engine has room and lines remain
    assign do_read = (remaining != 16'd0) && !almost_full && !start;

    always_ff @(posedge clk)
    begin
        if (fill_hit)
            mem[fill.index[AW-1:0]] <= fill.data;
        if (do_read)
            rd_line <= mem[rd_addr];  // data shows up one cycle after the read
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_addr   <= '0;
            remaining <= '0;
            rd_valid  <= 1'b0;
        end
        else
        begin
            rd_valid <= do_read;
            if (start)
            begin
                rd_addr   <= AW'(cfg.first_index);
                remaining <= cfg.count;
            end
            else if (do_read)
            begin
                remaining <= remaining - 16'd1;
                if (rd_addr == AW'(CHANNEL_DEPTH - 1))
                    rd_addr <= '0;  // wrap back to the start of the buffer
                else
                    rd_addr <= rd_addr + 1'b1;
            end
        end
    end

endmodule

// File: verilog/writeback_engine.sv
module writeback_engine #(
    parameter int NUM_CHANNELS = 2
) (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       start,
    input  wbk_cfg_pkg::wb_cmd_t       cmd,

    input  host_mem_pkg::line_t        rd_line [NUM_CHANNELS],
    input  logic                       rd_valid [NUM_CHANNELS],
    output logic                       almost_full [NUM_CHANNELS],

    input  logic                       host_almost_full,
    input  host_mem_pkg::host_wr_rsp_t rsp,
    output host_mem_pkg::host_wr_req_t req,
    output logic                       op_done
);

    typedef enum logic [1:0]
    {
        STATE_IDLE,
        STATE_PREPROCESS,
        STATE_WRITE,
        STATE_DONE
    } send_state_t;

    send_state_t              state;

    // command copy taken at start
    logic [2:0][31:0]         offsets;
    host_mem_pkg::line_addr_t base;
    logic [31:0]              length;
    logic [2:0]               sel_channel;
    logic                     fence;
    logic                     synthetic;

    logic [1:0]               offset_idx;
    logic [31:0]              sent_count;
    logic [31:0]              ack_count;
    logic                     host_af_q;

    host_mem_pkg::line_t      fifo_mem [4];
    logic [1:0]               wr_ptr;
    logic [1:0]               rd_ptr;
    logic [2:0]               fifo_count;

    logic                     sel_valid;
    host_mem_pkg::line_t      sel_line;
    logic                     send;

    always_comb
    begin
        sel_valid = 1'b0;
        sel_line  = '0;
        for (int c = 0; c < NUM_CHANNELS; c++)
        begin
            if (sel_channel == 3'(c))
            begin
                sel_valid = rd_valid[c];
                sel_line  = rd_line[c];
            end
            // only the selected reader may run, and only while the FIFO has room
            almost_full[c] = (sel_channel != 3'(c)) || (state == STATE_IDLE)
                          || (state == STATE_DONE) || (fifo_count >= 3'd2);
        end
    end

    // host_af_q holds last cycle's almost-full from the host
    assign send = (state == STATE_WRITE) && (fifo_count != 3'd0) && !host_af_q
               && (sent_count != length);

    always_comb
    begin
        req.valid = send;
        req.addr  = base + sent_count;
        if (synthetic)
            req.data = {host_mem_pkg::LINE_WORDS{sent_count}};  // line number in every word
        else
            req.data = fifo_mem[rd_ptr];
    end

    always_ff @(posedge clk)
    begin
        if (sel_valid)
            fifo_mem[wr_ptr] <= sel_line;
    end

    always_ff @(posedge clk)
    begin
        op_done <= 1'b0;
        if (reset)
        begin
            state      <= STATE_IDLE;
            host_af_q  <= 1'b1;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end
        else
        begin
            host_af_q <= host_almost_full;

            if (start)
            begin
                wr_ptr     <= '0;  // drop anything left over from the last run
                rd_ptr     <= '0;
                fifo_count <= '0;
            end
            else
            begin
                wr_ptr     <= wr_ptr + 2'(sel_valid);
                rd_ptr     <= rd_ptr + 2'(send);
                fifo_count <= fifo_count + 3'(sel_valid) - 3'(send);
            end

            case (state)
                STATE_IDLE:
                begin
                    if (start)
                    begin
                        offsets     <= cmd.offsets;
                        base        <= (cmd.store_in_base ? cmd.in_base : cmd.out_base)
                                     + {1'b0, cmd.store_offset};
                        length      <= cmd.length;
                        sel_channel <= cmd.channel;
                        fence       <= cmd.fence;
                        synthetic   <= cmd.synthetic;
                        offset_idx  <= 2'd0;
                        sent_count  <= '0;
                        ack_count   <= '0;
                        state       <= (cmd.length == 32'd0) ? STATE_DONE : STATE_PREPROCESS;
                    end
                end

                STATE_PREPROCESS:
                begin
                    base       <= base + offsets[offset_idx];  // one offset per cycle
                    offset_idx <= offset_idx + 2'd1;
                    if (offset_idx == 2'd2)
                        state <= STATE_WRITE;
                end

                STATE_WRITE:
                begin
                    if (send)
                    begin
                        sent_count <= sent_count + 32'd1;
                        if (!fence && (sent_count == length - 32'd1))
                        begin
                            op_done <= 1'b1;
                            state   <= STATE_IDLE;
                        end
                    end
                    if (rsp.valid)
                    begin
                        ack_count <= ack_count + 32'd1;
                        if (fence && (ack_count == length - 32'd1))
                        begin
                            op_done <= 1'b1;  // last write acknowledged
                            state   <= STATE_IDLE;
                        end
                    end
                end

                STATE_DONE:
                begin
                    op_done <= 1'b1;
                    state   <= STATE_IDLE;
                end

                default: state <= STATE_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/writeback_top.sv
module writeback_top #(
    parameter int NUM_CHANNELS  = 2,
    parameter int CHANNEL_DEPTH = 64
) (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  wbk_cfg_pkg::wb_addr_t      wb_adr,
    input  wbk_cfg_pkg::wb_data_t      wb_dat_w,
    output wbk_cfg_pkg::wb_data_t      wb_dat_r,
    output logic                       wb_ack,

    input  host_mem_pkg::line_fill_t   fill,

    output host_mem_pkg::host_wr_req_t req,
    input  host_mem_pkg::host_wr_rsp_t rsp,
    input  logic                       host_almost_full,
    output logic                       op_done
);

    logic                   start;
    wbk_cfg_pkg::wb_cmd_t   cmd;
    wbk_cfg_pkg::chan_cfg_t chan_cfg [NUM_CHANNELS];
    host_mem_pkg::line_t    rd_line [NUM_CHANNELS];
    logic                   rd_valid [NUM_CHANNELS];
    logic                   almost_full [NUM_CHANNELS];

    wbk_regfile #(.NUM_CHANNELS(NUM_CHANNELS)) u_regfile (
        .clk, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .op_done,
        .start,
        .cmd,
        .chan_cfg
    );

    for (genvar c = 0; c < NUM_CHANNELS; c++)
    begin : g_reader
        line_reader #(.CHANNEL_DEPTH(CHANNEL_DEPTH)) u_reader (
            .clk, .reset,
            .chan_id     (3'(c)),
            .fill        (fill),
            .start       (start),
            .cfg         (chan_cfg[c]),
            .almost_full (almost_full[c]),
            .rd_line     (rd_line[c]),
            .rd_valid    (rd_valid[c])
        );
    end

    writeback_engine #(.NUM_CHANNELS(NUM_CHANNELS)) u_engine (
        .clk, .reset,
        .start,
        .cmd,
        .rd_line,
        .rd_valid,
        .almost_full,
        .host_almost_full,
        .rsp,
        .req,
        .op_done
    );

endmodule

// File: tb/tb_host_mem.sv
module tb_host_mem (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       af_enable,
    input  host_mem_pkg::host_wr_req_t req,
    output host_mem_pkg::host_wr_rsp_t rsp,
    output logic                       host_almost_full,
    output int                         pending,
    output int                         rsp_total
);

    int seed;
    int cycle;
    int last_due;
    int due;
    int af_left;
    int due_q [$];   // cycle in which each outstanding write gets its response

    initial
    begin
        seed             = 32'h55f2;
        cycle            = 0;
        last_due         = 0;
        af_left          = 0;
        rsp              = '0;
        host_almost_full = 1'b0;
        pending          = 0;
        rsp_total        = 0;
    end

    // everything toward the DUT changes on the falling edge
    always @(negedge clk)
    begin
        if (reset)
        begin
            cycle            = 0;
            last_due         = 0;
            af_left          = 0;
            due_q.delete();
            rsp              = '0;
            host_almost_full = 1'b0;
        end
        else
        begin
            cycle++;
            if (req.valid)
            begin
                due = cycle + 1 + int'($unsigned($random(seed)) % 8);
                if (due <= last_due)
                    due = last_due + 1;  // responses keep request order
                last_due = due;
                due_q.push_back(due);
            end
            rsp.valid = (due_q.size() != 0) && (due_q[0] == cycle);
            if (rsp.valid)
            begin
                void'(due_q.pop_front());
                rsp_total++;
            end
            if (af_left != 0)
                af_left--;
            else if (af_enable && ($unsigned($random(seed)) % 4 == 0))
                af_left = 1 + int'($unsigned($random(seed)) % 4);  // busy for 1 to 4 cycles
            host_almost_full = (af_left != 0);
        end
        pending = due_q.size();
    end

endmodule

// File: tb/tb_writeback.sv
module tb_writeback;

    localparam int NUM_CHANNELS    = 2;
    localparam int CHANNEL_DEPTH   = 64;
    localparam logic [31:0] IN_BASE  = 32'h0010_0000;
    localparam logic [31:0] OUT_BASE = 32'h0080_0000;
    localparam int TEST_LINES      = 12 + 10 + 8 + 16 + 16 + 24 + 0;  // lengths of the runs below
    localparam int TIMEOUT_CYCLES  = TEST_LINES * 200;

    logic                       clk;
    logic                       reset;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    wbk_cfg_pkg::wb_addr_t      wb_adr;
    wbk_cfg_pkg::wb_data_t      wb_dat_w;
    wbk_cfg_pkg::wb_data_t      wb_dat_r;
    logic                       wb_ack;
    host_mem_pkg::line_fill_t   fill;
    host_mem_pkg::host_wr_req_t req;
    host_mem_pkg::host_wr_rsp_t rsp;
    logic                       host_almost_full;
    logic                       op_done;
    logic                       af_enable;
    int                         host_pending;
    int                         rsp_total;

    host_mem_pkg::line_addr_t   exp_addr_q [$];  // expected requests with the oldest first
    host_mem_pkg::line_t        exp_data_q [$];
    host_mem_pkg::line_t        shadow [NUM_CHANNELS][CHANNEL_DEPTH];
    host_mem_pkg::line_addr_t   chk_addr;        // expectation for this cycle's request
    host_mem_pkg::line_t        chk_data;
    logic                       chk_hit = 1'b0;
    logic                       fence_mode = 1'b0;
    int exp_left = 0;
    int req_count = 0;
    int op_done_count = 0;
    int ack_count = 0;
    int access_count = 0;
    int cur_length = -1;
    int rsp_base = 0;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    string test_name = "reset";

    writeback_top #(.NUM_CHANNELS(NUM_CHANNELS), .CHANNEL_DEPTH(CHANNEL_DEPTH)) UUT (
        .clk, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .fill, .req, .rsp, .host_almost_full, .op_done
    );

    tb_host_mem host_model (
        .clk, .reset, .af_enable, .req, .rsp, .host_almost_full,
        .pending   (host_pending),
        .rsp_total (rsp_total)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // DUT outputs are stable at the falling edge so the queue head is taken here
    always @(negedge clk)
    begin
        if (op_done)
            op_done_count++;
        if (wb_ack)
            ack_count++;
        if (req.valid)
        begin
            req_count++;
            chk_hit = (exp_addr_q.size() != 0);
            if (chk_hit)
            begin
                chk_addr = exp_addr_q.pop_front();
                chk_data = exp_data_q.pop_front();
            end
        end
        exp_left = exp_addr_q.size();
    end

    task automatic flag_error(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    a_req_known: assert property (@(posedge clk) disable iff (reset) req.valid |-> chk_hit)
        else flag_error($sformatf("%0t: write request issued with no line left to send",
                                  $time));
    a_req_addr: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> (req.addr == chk_addr))
        else flag_error($sformatf("ERR %0t req.addr exp=%h got=%h", $time,
                                  $sampled(chk_addr), $sampled(req.addr)));
    a_req_data: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> (req.data == chk_data))
        else flag_error($sformatf("ERR %0t req.data exp=%h got=%h", $time,
                                  $sampled(chk_data), $sampled(req.data)));
    a_host_af: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> !$past(host_almost_full))
        else flag_error($sformatf("%0t: request sent while the host was almost full", $time));
    a_ack_pulse: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else flag_error($sformatf("%0t: wb_ack stayed high for more than one cycle", $time));
    a_all_sent: assert property (@(posedge clk) disable iff (reset) op_done |-> (exp_left == 0))
        else flag_error($sformatf("%0t: op_done came before every line was sent", $time));
    a_fence_order: assert property (@(posedge clk) disable iff (reset)
        (op_done && fence_mode) |-> (rsp_total - rsp_base >= cur_length))
        else flag_error($sformatf("%0t: fenced op_done came before the last response", $time));
    a_nofence_last: assert property (@(posedge clk) disable iff (reset)
        (op_done && !fence_mode && (cur_length != 0)) |-> $past(req.valid))
        else flag_error($sformatf("%0t: op_done did not follow the last request", $time));
    a_zero_start: assert property (@(posedge clk) disable iff (reset)
        ((cur_length == 0) && $past(UUT.start, 2)) |-> op_done)
        else flag_error($sformatf("%0t: zero length op_done missing two cycles after start",
                                  $time));
    a_zero_done: assert property (@(posedge clk) disable iff (reset)
        (op_done && (cur_length == 0)) |-> $past(UUT.start, 2))
        else flag_error($sformatf("%0t: zero length op_done at the wrong cycle", $time));

    // every line holds its channel and index, so any misplaced read shows up
    function automatic host_mem_pkg::line_t line_pattern(input int ch, input int idx);
        host_mem_pkg::line_t line;
        for (int w = 0; w < host_mem_pkg::LINE_WORDS; w++)
            line[w*32 +: 32] = {8'(160 + ch), 8'(w), 16'(idx)};
        return line;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else
        begin
            $display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
            err_count++;
        end
    endtask

    task automatic wb_write(input wbk_cfg_pkg::wb_addr_t addr, input wbk_cfg_pkg::wb_data_t data);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        @(negedge clk);
        while (!wb_ack)
            @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        access_count++;
    endtask

    task automatic wb_read(input wbk_cfg_pkg::wb_addr_t addr, output wbk_cfg_pkg::wb_data_t data);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        @(negedge clk);
        while (!wb_ack)
            @(negedge clk);
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        access_count++;
    endtask

    task automatic read_expect(input wbk_cfg_pkg::wb_addr_t addr, input logic [31:0] exp,
                               input string name);
        wbk_cfg_pkg::wb_data_t word;
        wb_read(addr, word);
        compare_word(name, exp, word);
    endtask

    task automatic write_read_back(input wbk_cfg_pkg::wb_addr_t addr, input logic [31:0] value,
                                   input logic [31:0] exp, input string name);
        wb_write(addr, value);
        read_expect(addr, exp, name);
    endtask

    task automatic report_test(input int errs_before);
        tests_run++;
        if (err_count == errs_before)
            $display("test '%s' ok", test_name);
        else
        begin
            tests_failed++;
            $display("test '%s' failed with %0d errors", test_name, err_count - errs_before);
        end
    endtask

    task automatic fill_channels();
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
        begin
            for (int idx = 0; idx < CHANNEL_DEPTH; idx++)
            begin
                @(negedge clk);
                fill = '{valid: 1'b1, channel: 3'(ch), index: 16'(idx),
                         data: line_pattern(ch, idx)};
                shadow[ch][idx] = fill.data;
            end
        end
        @(negedge clk);
        fill = '0;
    endtask

    task automatic register_test();
        int errs_before;
        int acks_before;
        int access_before;
        errs_before   = err_count;
        acks_before   = ack_count;
        access_before = access_count;
        test_name     = "register access";
        read_expect(wbk_cfg_pkg::REG_STATUS, 32'h0, "status after reset");
        write_read_back(wbk_cfg_pkg::REG_OFFSET0, 32'h1357_9bdf, 32'h1357_9bdf, "offset0");
        write_read_back(wbk_cfg_pkg::REG_OFFSET1, 32'hfedc_ba98, 32'hfedc_ba98, "offset1");
        write_read_back(wbk_cfg_pkg::REG_OFFSET2, 32'h0000_0001, 32'h0000_0001, "offset2");
        write_read_back(wbk_cfg_pkg::REG_STORE, 32'h8000_1234, 32'h8000_1234, "store");
        write_read_back(wbk_cfg_pkg::REG_LENGTH, 32'h0000_abcd, 32'h0000_abcd, "length");
        write_read_back(wbk_cfg_pkg::REG_IN_BASE, 32'h2468_ace0, 32'h2468_ace0, "in_base");
        write_read_back(wbk_cfg_pkg::REG_OUT_BASE, 32'h369c_0f1e, 32'h369c_0f1e, "out_base");
        write_read_back(6'd16, 32'h0011_0022, 32'h0011_0022, "chan_cfg0");
        write_read_back(6'd17, 32'h0033_0044, 32'h0033_0044, "chan_cfg1");
        write_read_back(wbk_cfg_pkg::REG_CONTROL, 32'hffff_feff, 32'h0000_0037, "control");
        read_expect(6'd9, 32'h0, "unmapped 9");
        read_expect(6'd18, 32'h0, "unmapped 18");
        read_expect(6'd63, 32'h0, "unmapped 63");
        @(negedge clk);  // let the monitor count the last ack
        compare_word("wb_ack pulses", 32'(access_count - access_before),
                     32'(ack_count - acks_before));
        report_test(errs_before);
    endtask

    task automatic run_op(input string name, input int chan, input logic in_sel,
                          input logic [30:0] store_off, input logic [31:0] off0,
                          input logic [31:0] off1, input logic [31:0] off2, input int first,
                          input int length, input logic fence, input logic synth,
                          input logic twice);
        logic [31:0] base;
        logic [31:0] ctrl;
        int          errs_before;
        int          req_before;
        int          done_before;
        errs_before = err_count;
        test_name   = name;
        wb_write(wbk_cfg_pkg::REG_OFFSET0, off0);
        wb_write(wbk_cfg_pkg::REG_OFFSET1, off1);
        wb_write(wbk_cfg_pkg::REG_OFFSET2, off2);
        wb_write(wbk_cfg_pkg::REG_STORE, {in_sel, store_off});
        wb_write(wbk_cfg_pkg::REG_LENGTH, 32'(length));
        wb_write(wbk_cfg_pkg::REG_IN_BASE, IN_BASE);
        wb_write(wbk_cfg_pkg::REG_OUT_BASE, OUT_BASE);
        wb_write(6'(16 + chan), {16'(first), 16'(length)});
        base = (in_sel ? IN_BASE : OUT_BASE) + {1'b0, store_off} + off0 + off1 + off2;
        for (int i = 0; i < length; i++)
        begin
            exp_addr_q.push_back(base + 32'(i));
            if (synth)
                exp_data_q.push_back({host_mem_pkg::LINE_WORDS{32'(i)}});
            else
                exp_data_q.push_back(shadow[chan][(first + i) % CHANNEL_DEPTH]);  // wraps
        end
        cur_length  = length;
        fence_mode  = fence;
        rsp_base    = rsp_total;
        req_before  = req_count;
        done_before = op_done_count;
        ctrl        = 32'(chan);
        ctrl[wbk_cfg_pkg::CTRL_FENCE_BIT] = fence;
        ctrl[wbk_cfg_pkg::CTRL_SYNTH_BIT] = synth;
        ctrl[wbk_cfg_pkg::CTRL_START_BIT] = 1'b1;
        wb_write(wbk_cfg_pkg::REG_CONTROL, ctrl);
        if (twice)
            wb_write(wbk_cfg_pkg::REG_CONTROL, ctrl);  // lands while busy and must do nothing
        while (op_done_count == done_before)
            @(negedge clk);
        while (host_pending != 0)
            @(negedge clk);  // stray responses would spill into the next run
        read_expect(wbk_cfg_pkg::REG_STATUS, 32'h2, "status");
        compare_word("request count", 32'(length), 32'(req_count - req_before));
        compare_word("op_done pulses", 32'd1, 32'(op_done_count - done_before));
        report_test(errs_before);
    endtask

    initial
    begin
        reset     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        fill      = '0;
        af_enable = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        fill_channels();
        register_test();
        run_op("channel 0 output base", 0, 1'b0, 31'h40, 0, 0, 0, 3, 12, 1'b0, 1'b0, 1'b0);
        run_op("channel 1 input base wrap", 1, 1'b1, 31'h7fff_fff0, 32'h10, 32'hffff_fffe,
               32'h3, 58, 10, 1'b0, 1'b0, 1'b0);
        run_op("synthetic data", 0, 1'b0, 31'h200, 32'h5, 0, 32'h7, 20, 8, 1'b0, 1'b1, 1'b0);
        run_op("fence", 1, 1'b0, 31'h1000, 32'h1, 32'h2, 0, 0, 16, 1'b1, 1'b0, 1'b0);
        run_op("no fence, start while busy", 0, 1'b1, 31'h80, 0, 32'h9, 0, 30, 16,
               1'b0, 1'b0, 1'b1);
        af_enable = 1'b1;
        run_op("host back-pressure", 1, 1'b0, 31'h300, 32'h4, 0, 32'h4, 40, 24,
               1'b0, 1'b0, 1'b0);
        af_enable = 1'b0;
        run_op("zero length", 0, 1'b0, 31'h0, 0, 0, 0, 0, 0, 1'b0, 1'b0, 1'b0);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired, test '%s' did not finish", test_name);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verilog.f
verilog/wbk_cfg_pkg.sv
verilog/host_mem_pkg.sv
verilog/wbk_regfile.sv
verilog/line_reader.sv
verilog/writeback_engine.sv
verilog/writeback_top.sv
tb/tb_host_mem.sv
tb/tb_writeback.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_writeback -f verilog.f \
    -o tb_writeback_sim \
    && ./obj_dir/tb_writeback_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Done: no errors$" sim.log \
    && echo "simulation passed" \
    && exit 0
echo "simulation failed" \
    || true
exit 1
